//--- all.f
hdl/blimp_isa_pkg.sv
hdl/blimp_uarch_pkg.sv
hdl/decode_issue_unit.sv
hdl/alu_unit.sv
hdl/pipelined_multiplier.sv
hdl/writeback_commit_unit.sv
hdl/blimp_core.sv
verification/clock_gen.sv
verification/blimp_core_tb.sv

//--- hdl/alu_unit.sv
// Single-cycle integer execution unit
// li, add, sub, and, xor with a registered result
`timescale 1ns/10ps

module alu_unit (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       issue_val,
  input  blimp_uarch_pkg::issue_t    issue,
  output logic                       complete_val,
  output blimp_uarch_pkg::complete_t complete
);

  localparam int pad_width = blimp_isa_pkg::data_width - blimp_isa_pkg::imm_width;

  logic [blimp_isa_pkg::data_width-1:0] result;

  // Operation select
  always_comb begin
    case (issue.opcode)
      blimp_isa_pkg::op_li:  result = {{pad_width{1'b0}}, issue.imm};
      blimp_isa_pkg::op_add: result = issue.operand_a + issue.operand_b;
      blimp_isa_pkg::op_sub: result = issue.operand_a - issue.operand_b;
      blimp_isa_pkg::op_and: result = issue.operand_a & issue.operand_b;
      blimp_isa_pkg::op_xor: result = issue.operand_a ^ issue.operand_b;
      // mul never reaches this unit
      default:               result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) complete_val <= 1'b0;
    else       complete_val <= issue_val;
  end

  // Tag travels with the result
  always_ff @(posedge clk) begin
    if (issue_val) begin
      complete.seq_num <= issue.seq_num;
      complete.rd      <= issue.rd;
      complete.result  <= result;
    end
  end

endmodule

//--- hdl/blimp_core.sv
// Core top level
// Decode-issue, ALU, pipelined multiplier and writeback-commit joined by struct wires
`timescale 1ns/10ps

module blimp_core #(
  parameter int p_seq_num_bits = 3,
  parameter int p_mul_stages   = 3
) (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inst_req,
  input  blimp_isa_pkg::inst_t     inst,
  output logic                     inst_ack,
  output logic                     trace_val,
  output blimp_uarch_pkg::commit_t trace
);

  // --------------------------------------------------
  // Internal bundles
  // --------------------------------------------------

  logic                       alu_issue_val;
  blimp_uarch_pkg::issue_t    alu_issue;
  logic                       mul_issue_val;
  blimp_uarch_pkg::issue_t    mul_issue;
  logic                       alu_complete_val;
  blimp_uarch_pkg::complete_t alu_complete;
  logic                       mul_complete_val;
  blimp_uarch_pkg::complete_t mul_complete;
  logic                       commit_val;
  blimp_uarch_pkg::commit_t   commit;
  logic                       rob_full;
  logic                       issue_seen;

  // Either unit taking an op claims a ROB slot
  assign issue_seen = alu_issue_val | mul_issue_val;

  // Commits are published as the trace
  assign trace_val = commit_val;
  assign trace     = commit;

  // --------------------------------------------------
  // Units
  // --------------------------------------------------

  decode_issue_unit u_diu (
    .clk           (clk),
    .reset         (reset),
    .inst_req      (inst_req),
    .inst          (inst),
    .inst_ack      (inst_ack),
    .rob_full      (rob_full),
    .commit_val    (commit_val),
    .commit        (commit),
    .alu_issue_val (alu_issue_val),
    .alu_issue     (alu_issue),
    .mul_issue_val (mul_issue_val),
    .mul_issue     (mul_issue)
  );

  alu_unit u_alu (
    .clk          (clk),
    .reset        (reset),
    .issue_val    (alu_issue_val),
    .issue        (alu_issue),
    .complete_val (alu_complete_val),
    .complete     (alu_complete)
  );

  pipelined_multiplier #(
    .p_mul_stages (p_mul_stages)
  ) u_mul (
    .clk          (clk),
    .reset        (reset),
    .issue_val    (mul_issue_val),
    .issue        (mul_issue),
    .complete_val (mul_complete_val),
    .complete     (mul_complete)
  );

  writeback_commit_unit #(
    .p_seq_num_bits (p_seq_num_bits)
  ) u_wcu (
    .clk              (clk),
    .reset            (reset),
    .alu_complete_val (alu_complete_val),
    .alu_complete     (alu_complete),
    .mul_complete_val (mul_complete_val),
    .mul_complete     (mul_complete),
    .issue_seen       (issue_seen),
    .rob_full         (rob_full),
    .commit_val       (commit_val),
    .commit           (commit)
  );

endmodule

//--- hdl/blimp_isa_pkg.sv
// Architectural definitions for the core
// Data and register widths, opcodes, decoded instruction format

package blimp_isa_pkg;

  // Register data width
  localparam int data_width = 32;

  // Eight architectural registers
  localparam int reg_addr_width = 3;

  // Immediate is zero-extended to data_width
  localparam int imm_width = 16;

  // Supported opcodes
  typedef enum logic [2:0] {
    op_li,
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_mul
  } opcode_e;

  // Decoded instruction as presented on the instruction port
  typedef struct packed {
    opcode_e                   opcode;
    logic [reg_addr_width-1:0] rd;
    logic [reg_addr_width-1:0] rs1;
    logic [reg_addr_width-1:0] rs2;
    logic [imm_width-1:0]      imm;
  } inst_t;

endpackage

//--- hdl/blimp_uarch_pkg.sv
// Microarchitectural definitions for the core
// Unit select, issue, complete and commit bundles

package blimp_uarch_pkg;

  // Widest sequence number any configuration may use
  // Smaller reorder buffers take the low bits
  localparam int max_seq_bits = 5;

  // Execution unit targets
  typedef enum logic {
    unit_alu,
    unit_mul
  } unit_e;

  // Operation sent from decode to an execution unit
  typedef struct packed {
    blimp_isa_pkg::opcode_e                      opcode;
    logic [max_seq_bits-1:0]                     seq_num;
    logic [blimp_isa_pkg::reg_addr_width-1:0]    rd;
    logic [blimp_isa_pkg::data_width-1:0]        operand_a;
    logic [blimp_isa_pkg::data_width-1:0]        operand_b;
    logic [blimp_isa_pkg::imm_width-1:0]         imm;
  } issue_t;

  // Finished result from an execution unit
  typedef struct packed {
    logic [max_seq_bits-1:0]                  seq_num;
    logic [blimp_isa_pkg::reg_addr_width-1:0] rd;
    logic [blimp_isa_pkg::data_width-1:0]     result;
  } complete_t;

  // Result retired in program order
  typedef struct packed {
    logic [max_seq_bits-1:0]                  seq_num;
    logic [blimp_isa_pkg::reg_addr_width-1:0] waddr;
    logic [blimp_isa_pkg::data_width-1:0]     wdata;
  } commit_t;

endpackage

//--- hdl/decode_issue_unit.sv
// Decode and issue stage
// Register file, pending-write scoreboard, four-phase instruction port,
// in-order dispatch to the ALU and the multiplier
`timescale 1ns/10ps

module decode_issue_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     inst_req,
  input  blimp_isa_pkg::inst_t     inst,
  output logic                     inst_ack,
  input  logic                     rob_full,
  input  logic                     commit_val,
  input  blimp_uarch_pkg::commit_t commit,
  output logic                     alu_issue_val,
  output blimp_uarch_pkg::issue_t  alu_issue,
  output logic                     mul_issue_val,
  output blimp_uarch_pkg::issue_t  mul_issue
);

  // ack_low is the cycle right after an exchange closes
  typedef enum logic [1:0] {
    idle,
    ack_high,
    ack_low
  } state_e;

  localparam int num_regs = 1 << blimp_isa_pkg::reg_addr_width;

  state_e                                   state_q;
  logic [blimp_isa_pkg::data_width-1:0]     regs_q [num_regs];
  logic [num_regs-1:0]                      pending_q;
  logic [blimp_uarch_pkg::max_seq_bits-1:0] seq_q;
  blimp_uarch_pkg::issue_t                  issue_q;
  blimp_uarch_pkg::unit_e                   target;
  logic                                     uses_rs;
  logic                                     hazard;
  logic                                     fire;

  // --------------------------------------------------
  // Decode and hazard check
  // --------------------------------------------------

  // Only mul goes to the multiplier
  always_comb begin
    case (inst.opcode)
      blimp_isa_pkg::op_mul: target = blimp_uarch_pkg::unit_mul;
      default:               target = blimp_uarch_pkg::unit_alu;
    endcase
  end

  // li reads no source registers
  assign uses_rs = (inst.opcode != blimp_isa_pkg::op_li);

  // No bypass, so wait on any in-flight write to rd, rs1 or rs2
  assign hazard = pending_q[inst.rd]
                | (uses_rs & (pending_q[inst.rs1] | pending_q[inst.rs2]));

  assign fire = inst_req & (state_q != ack_high) & ~hazard & ~rob_full;

  // --------------------------------------------------
  // Four-phase port
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
    end else begin
      case (state_q)
        // Hold ack until the request drops
        ack_high: if (!inst_req) state_q <= ack_low;
        default:  state_q <= fire ? ack_high : idle;
      endcase
    end
  end

  assign inst_ack = (state_q == ack_high);

  // --------------------------------------------------
  // Register file, scoreboard, sequence numbers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      pending_q <= '0;
      seq_q     <= '0;
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
      end
    end else begin
      // Commit writes back and frees the register
      if (commit_val) begin
        regs_q[commit.waddr]    <= commit.wdata;
        pending_q[commit.waddr] <= 1'b0;
      end
      // Claim rd at issue
      if (fire) begin
        pending_q[inst.rd] <= 1'b1;
        seq_q              <= seq_q + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Issue registers
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      alu_issue_val <= 1'b0;
      mul_issue_val <= 1'b0;
    end else begin
      alu_issue_val <= fire & (target == blimp_uarch_pkg::unit_alu);
      mul_issue_val <= fire & (target == blimp_uarch_pkg::unit_mul);
    end
  end

  // Operands read straight from the register file
  always_ff @(posedge clk) begin
    if (fire) begin
      issue_q.opcode    <= inst.opcode;
      issue_q.seq_num   <= seq_q;
      issue_q.rd        <= inst.rd;
      issue_q.operand_a <= regs_q[inst.rs1];
      issue_q.operand_b <= regs_q[inst.rs2];
      issue_q.imm       <= inst.imm;
    end
  end

  // One payload, the valids pick the unit
  assign alu_issue = issue_q;
  assign mul_issue = issue_q;

endmodule

//--- hdl/pipelined_multiplier.sv
// Multiply unit pipelined over a configurable number of stages
// Low word of the product, one new multiply per cycle
`timescale 1ns/10ps

module pipelined_multiplier #(
  parameter int p_mul_stages = 3
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       issue_val,
  input  blimp_uarch_pkg::issue_t    issue,
  output logic                       complete_val,
  output blimp_uarch_pkg::complete_t complete
);

  localparam int dw = blimp_isa_pkg::data_width;

  logic [2*dw-1:0]            full_product;
  logic [p_mul_stages-1:0]    val_q;
  blimp_uarch_pkg::complete_t stage_q [p_mul_stages];

  assign full_product = issue.operand_a * issue.operand_b;

  // --------------------------------------------------
  // Stage valids
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      val_q <= '0;
    end else begin
      val_q[0] <= issue_val;
      for (int i = 1; i < p_mul_stages; i++) begin
        val_q[i] <= val_q[i-1];
      end
    end
  end

  // --------------------------------------------------
  // Stage payload
  // --------------------------------------------------

  // First stage captures the truncated product and tag
  always_ff @(posedge clk) begin
    stage_q[0].seq_num <= issue.seq_num;
    stage_q[0].rd      <= issue.rd;
    stage_q[0].result  <= full_product[dw-1:0];
    // Later stages just carry it along
    for (int i = 1; i < p_mul_stages; i++) begin
      stage_q[i] <= stage_q[i-1];
    end
  end

  // Last stage is the output
  assign complete_val = val_q[p_mul_stages-1];
  assign complete     = stage_q[p_mul_stages-1];

endmodule

//--- hdl/writeback_commit_unit.sv
// Reorder buffer with in-order commit
// Two completion write ports, one commit per cycle, commit also drives the trace
`timescale 1ns/10ps

module writeback_commit_unit #(
  parameter int p_seq_num_bits = 3
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       alu_complete_val,
  input  blimp_uarch_pkg::complete_t alu_complete,
  input  logic                       mul_complete_val,
  input  blimp_uarch_pkg::complete_t mul_complete,
  input  logic                       issue_seen,
  output logic                       rob_full,
  output logic                       commit_val,
  output blimp_uarch_pkg::commit_t   commit
);

  localparam int depth = 1 << p_seq_num_bits;

  logic [blimp_isa_pkg::reg_addr_width-1:0] rob_rd   [depth];
  logic [blimp_isa_pkg::data_width-1:0]     rob_data [depth];
  logic [depth-1:0]                         done_q;
  logic [p_seq_num_bits-1:0]                head_q;
  logic [p_seq_num_bits:0]                  count_q;
  logic [p_seq_num_bits-1:0]                alu_idx;
  logic [p_seq_num_bits-1:0]                mul_idx;
  logic [blimp_uarch_pkg::max_seq_bits-1:0] head_seq;
  logic                                     head_done;

  // ROB slot is the low bits of the sequence number
  assign alu_idx = alu_complete.seq_num[p_seq_num_bits-1:0];
  assign mul_idx = mul_complete.seq_num[p_seq_num_bits-1:0];

  assign head_done = done_q[head_q];

  // Count tops out at depth, so the MSB alone means full
  assign rob_full = count_q[p_seq_num_bits];

  // Trace shows sequence numbers modulo the ROB depth
  always_comb begin
    head_seq                       = '0;
    head_seq[p_seq_num_bits-1:0]   = head_q;
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      done_q     <= '0;
      head_q     <= '0;
      count_q    <= '0;
      commit_val <= 1'b0;
    end else begin
      if (alu_complete_val) done_q[alu_idx] <= 1'b1;
      if (mul_complete_val) done_q[mul_idx] <= 1'b1;
      // Retire oldest entry once done
      if (head_done) begin
        done_q[head_q] <= 1'b0;
        head_q         <= head_q + 1'b1;
      end
      commit_val <= head_done;
      // Occupancy, grows at issue and shrinks at commit
      case ({issue_seen, head_done})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // --------------------------------------------------
  // Result storage and commit payload
  // --------------------------------------------------

  always_ff @(posedge clk) begin
    if (alu_complete_val) begin
      rob_rd[alu_idx]   <= alu_complete.rd;
      rob_data[alu_idx] <= alu_complete.result;
    end
    if (mul_complete_val) begin
      rob_rd[mul_idx]   <= mul_complete.rd;
      rob_data[mul_idx] <= mul_complete.result;
    end
    if (head_done) begin
      commit.seq_num <= head_seq;
      commit.waddr   <= rob_rd[head_q];
      commit.wdata   <= rob_data[head_q];
    end
  end

endmodule

//--- verification/blimp_core_tb.sv
// Directed testbench for the core
// Register model, expected-commit queue, trace and handshake monitors, watchdog
`timescale 1ns/10ps

module blimp_core_tb;

  localparam int seq_bits        = 3;
  localparam int mul_stages      = 3;
  localparam int rob_depth       = 1 << seq_bits;
  localparam int reset_cycles    = 10;
  // 8 + 5 + 4 + 1 + 20 instructions over all tests
  localparam int total_insts     = 38;
  localparam int cycles_per_inst = 200;

  logic                     clk;
  logic                     reset;
  logic                     inst_req;
  blimp_isa_pkg::inst_t     inst;
  logic                     inst_ack;
  logic                     trace_val;
  blimp_uarch_pkg::commit_t trace;

  logic [31:0]              model_regs [8];
  blimp_uarch_pkg::commit_t exp_q [$];
  blimp_uarch_pkg::commit_t exp_entry;
  int                       sent_count;
  logic                     prev_ack;
  logic                     prev_req;

  clock_gen #(
    .p_period       (8),
    .p_reset_cycles (reset_cycles)
  ) u_clk (
    .clk   (clk),
    .reset (reset)
  );

  blimp_core #(
    .p_seq_num_bits (seq_bits),
    .p_mul_stages   (mul_stages)
  ) u_dut (
    .clk       (clk),
    .reset     (reset),
    .inst_req  (inst_req),
    .inst      (inst),
    .inst_ack  (inst_ack),
    .trace_val (trace_val),
    .trace     (trace)
  );

  // --------------------------------------------------
  // Failure reporting and checks
  // --------------------------------------------------

  task automatic stop_with_failure(input string what);
    $display("%s (time %0t)", what, $time);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("mismatch at %0t: %s is 0x%08h, expected 0x%08h",
               $time, name, actual, expected);
      stop_with_failure("value check failed");
    end
  endtask

  // --------------------------------------------------
  // Reference model and stimulus
  // --------------------------------------------------

  function automatic blimp_isa_pkg::inst_t make_inst(input blimp_isa_pkg::opcode_e op,
                                                     input int rd, input int rs1,
                                                     input int rs2, input int imm);
    blimp_isa_pkg::inst_t i;
    i.opcode = op;
    i.rd     = rd[2:0];
    i.rs1    = rs1[2:0];
    i.rs2    = rs2[2:0];
    i.imm    = imm[15:0];
    return i;
  endfunction

  // Program-order model update with one expected commit per instruction
  task automatic record_expected(input blimp_isa_pkg::inst_t i);
    blimp_uarch_pkg::commit_t c;
    logic [31:0]              a;
    logic [31:0]              b;
    a = model_regs[i.rs1];
    b = model_regs[i.rs2];
    c.seq_num = 5'(sent_count % rob_depth);
    c.waddr   = i.rd;
    case (i.opcode)
      blimp_isa_pkg::op_li:  c.wdata = {16'h0000, i.imm};
      blimp_isa_pkg::op_add: c.wdata = a + b;
      blimp_isa_pkg::op_sub: c.wdata = a - b;
      blimp_isa_pkg::op_and: c.wdata = a & b;
      blimp_isa_pkg::op_xor: c.wdata = a ^ b;
      default:               c.wdata = a * b;
    endcase
    model_regs[i.rd] = c.wdata;
    exp_q.push_back(c);
    sent_count++;
  endtask

  // Full four-phase exchange
  task automatic send_inst(input blimp_isa_pkg::inst_t i);
    record_expected(i);
    @(posedge clk);
    inst     <= i;
    inst_req <= 1'b1;
    @(negedge clk);
    while (!inst_ack) @(negedge clk);
    @(posedge clk);
    inst_req <= 1'b0;
    @(negedge clk);
    while (inst_ack) @(negedge clk);
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------

  task automatic alu_ops_test();
    send_inst(make_inst(blimp_isa_pkg::op_li, 1, 0, 0, 'h1234));
    send_inst(make_inst(blimp_isa_pkg::op_li, 2, 0, 0, 'h00ff));
    send_inst(make_inst(blimp_isa_pkg::op_li, 3, 0, 0, 'hf0f0));
    send_inst(make_inst(blimp_isa_pkg::op_add, 4, 1, 2, 0));
    send_inst(make_inst(blimp_isa_pkg::op_sub, 5, 1, 2, 0));
    send_inst(make_inst(blimp_isa_pkg::op_and, 6, 1, 3, 0));
    send_inst(make_inst(blimp_isa_pkg::op_xor, 7, 2, 3, 0));
    // Negative result wraps
    send_inst(make_inst(blimp_isa_pkg::op_sub, 5, 2, 1, 0));
  endtask

  // Younger ALU ops behind a mul still commit in order
  task automatic out_of_order_test();
    send_inst(make_inst(blimp_isa_pkg::op_li, 1, 0, 0, 'h0007));
    send_inst(make_inst(blimp_isa_pkg::op_li, 2, 0, 0, 'h0009));
    send_inst(make_inst(blimp_isa_pkg::op_mul, 3, 1, 2, 0));
    send_inst(make_inst(blimp_isa_pkg::op_li, 4, 0, 0, 'h0055));
    send_inst(make_inst(blimp_isa_pkg::op_add, 5, 1, 2, 0));
  endtask

  // add waits for the product it reads
  task automatic dependency_test();
    send_inst(make_inst(blimp_isa_pkg::op_li, 1, 0, 0, 'h1000));
    send_inst(make_inst(blimp_isa_pkg::op_li, 2, 0, 0, 'h0003));
    send_inst(make_inst(blimp_isa_pkg::op_mul, 3, 1, 2, 0));
    send_inst(make_inst(blimp_isa_pkg::op_add, 4, 3, 1, 0));
  endtask

  // Request held after ack so ack must hold with it
  task automatic handshake_test();
    blimp_isa_pkg::inst_t i;
    i = make_inst(blimp_isa_pkg::op_li, 6, 0, 0, 'hbeef);
    record_expected(i);
    @(posedge clk);
    inst     <= i;
    inst_req <= 1'b1;
    @(negedge clk);
    while (!inst_ack) @(negedge clk);
    repeat (3) begin
      @(negedge clk);
      check_value("inst_ack", inst_ack, 1'b1);
    end
    @(posedge clk);
    inst_req <= 1'b0;
    @(negedge clk);
    while (inst_ack) @(negedge clk);
  endtask

  // Random mix, rd rotating over 1 to 7, sequence numbers wrap
  task automatic rob_wrap_test();
    blimp_isa_pkg::opcode_e op;
    for (int n = 0; n < 20; n++) begin
      op = blimp_isa_pkg::opcode_e'($urandom_range(0, 5));
      send_inst(make_inst(op, 1 + (n % 7), $urandom_range(0, 7), $urandom_range(0, 7),
                          $urandom_range(0, 65535)));
    end
  endtask

  // --------------------------------------------------
  // Monitors and watchdog
  // --------------------------------------------------

  // One trace entry per instruction, in program order
  always @(negedge clk) begin
    if (!reset && trace_val) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("trace entry with no instruction outstanding");
      end else begin
        exp_entry = exp_q.pop_front();
        check_value("trace.seq_num", trace.seq_num, exp_entry.seq_num);
        check_value("trace.waddr", trace.waddr, exp_entry.waddr);
        check_value("trace.wdata", trace.wdata, exp_entry.wdata);
      end
    end
  end

  // Ack edges against the request seen at that edge
  always @(negedge clk) begin
    if (!reset) begin
      if (!prev_ack && inst_ack && !prev_req) begin
        stop_with_failure("inst_ack rose with inst_req low");
      end else if (prev_ack && !inst_ack && prev_req) begin
        stop_with_failure("inst_ack fell with inst_req high");
      end
    end
    prev_ack = inst_ack;
    prev_req = inst_req;
  end

  initial begin : watchdog
    repeat (reset_cycles + total_insts * cycles_per_inst) @(posedge clk);
    stop_with_failure("watchdog expired, the core stopped making progress");
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    inst_req   = 1'b0;
    inst       = '0;
    sent_count = 0;
    prev_ack   = 1'b0;
    prev_req   = 1'b0;
    for (int r = 0; r < 8; r++) begin
      model_regs[r] = '0;
    end
    void'($urandom(32'heec3));
    @(negedge clk);
    while (reset) @(negedge clk);
    check_value("inst_ack", inst_ack, 1'b0);
    check_value("trace_val", trace_val, 1'b0);
    alu_ops_test();
    out_of_order_test();
    dependency_test();
    handshake_test();
    rob_wrap_test();
    // Drain and give any extra commit time to show up
    while (exp_q.size() != 0) @(negedge clk);
    repeat (20) @(negedge clk);
    $display("NO ERRORS");
    $finish;
  end

endmodule

//--- verification/clock_gen.sv
// Testbench clock and synchronous reset source
`timescale 1ns/10ps

module clock_gen #(
  parameter int p_period       = 8,
  parameter int p_reset_cycles = 10
) (
  output logic clk,
  output logic reset
);

  // Free-running clock
  initial begin
    clk = 1'b0;
    forever #(p_period / 2) clk = ~clk;
  end

  // Reset held for a fixed number of edges
  initial begin
    reset = 1'b1;
    repeat (p_reset_cycles) @(posedge clk);
    reset <= 1'b0;
  end

endmodule
